// File: Bender.yml
package:
  name: aes_decrypt_accel

export_include_dirs:
  - .

sources:
  - files:
      - aes_pkg.sv
      - host_io_port.sv
      - aes_key_schedule.sv
      - aes_inv_round.sv
      - aes_decrypt_core.sv
      - aes_decrypt_top.sv
  - target: test
    files:
      - aes_decrypt_tb.sv

// File: aes_decrypt_core.sv
// AES-128 iterative decrypt engine
`timescale 1ns/1ns
`include "aes_defs.svh"

module aes_decrypt_core (
        input  logic                clk,
        input  logic                reset_n,
        input  aes_pkg::aes_job_t   job,
        input  logic                start,
        output aes_pkg::aes_block_t plain,
        output logic                ready
);
        import aes_pkg::*;

        typedef enum logic [1:0] {IDLE, EXPAND, WHITEN, ROUNDS} phase_t;

        phase_t     phase;
        logic [3:0] cnt;
        logic       last;
        logic       expand;
        logic       back;
        aes_block_t state_q;
        aes_block_t round_key;
        aes_block_t round_out;

        assign last   = (phase == ROUNDS) && (cnt == 4'(`AES_ROUNDS));
        assign expand = (phase == EXPAND);
        assign back   = (phase == WHITEN) || (phase == ROUNDS && !last); // key 0 is the end

        aes_key_schedule u_key (
                .clk       (clk),
                .reset_n   (reset_n),
                .load      (start),
                .key       (job.key),
                .expand    (expand),
                .back      (back),
                .round_key (round_key)
        );

        aes_inv_round u_round (
                .state_in  (state_q),
                .round_key (round_key),
                .last      (last),
                .state_out (round_out)
        );

        always_ff @(posedge clk, negedge reset_n) begin
                if (!reset_n) begin
                        phase <= IDLE;
                        cnt   <= '0;
                        ready <= 1'b0;
                end else if (start) begin
                        phase <= EXPAND;
                        cnt   <= '0;
                        ready <= 1'b0;
                end else begin
                        case (phase)
                        EXPAND: begin
                                cnt <= cnt + 4'd1;
                                if (cnt == 4'(`AES_ROUNDS - 1)) begin // round-10 key next
                                        phase <= WHITEN;
                                        cnt   <= 4'd1;
                                end
                        end
                        WHITEN: begin
                                phase <= ROUNDS;
                        end
                        ROUNDS: begin
                                cnt <= cnt + 4'd1;
                                if (last) begin
                                        phase <= IDLE;
                                        cnt   <= '0;
                                        ready <= 1'b1;
                                end
                        end
                        default: begin
                                phase <= IDLE;
                        end
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (start) begin
                        state_q <= job.cipher;
                end else if (phase == WHITEN) begin
                        state_q <= state_q ^ round_key;
                end else if (phase == ROUNDS) begin
                        state_q <= round_out;
                end
        end

        assign plain = state_q;

        a_start_idle: assert property (@(posedge clk) disable iff (!reset_n)
                start |-> phase == IDLE)
                else $error("start while a decrypt is running");

        a_ready_fall: assert property (@(posedge clk) disable iff (!reset_n)
                $fell(ready) |-> $past(start))
                else $error("ready dropped without a start");

endmodule

// File: aes_decrypt_tb.sv
// AES decrypt accelerator testbench
`timescale 1ns/1ns
`include "aes_defs.svh"

module aes_decrypt_tb;

        localparam int         MAX_PATS = 16;
        localparam int         TIMEOUT  = 200; // cycles per wait
        localparam logic [1:0] CMD_MSG  = 2'd1;
        localparam logic [1:0] CMD_KEY  = 2'd2;
        localparam logic [1:0] CMD_RUN  = 2'd3;

        logic                      clk;
        logic                      reset_n;
        logic [1:0]                to_hw_sig;
        logic [`AES_HOST_WORD-1:0] to_hw_port;
        logic [1:0]                to_sw_sig;
        logic [`AES_HOST_WORD-1:0] to_sw_port;

        logic [`AES_BLOCK_BITS-1:0] pats [0:3*MAX_PATS-1]; // key, cipher, plain per pattern
        int                         ack_count = 0;         // steps the acknowledge length

        aes_decrypt_top UUT (
                .clk        (clk),
                .reset_n    (reset_n),
                .to_hw_sig  (to_hw_sig),
                .to_hw_port (to_hw_port),
                .to_sw_sig  (to_sw_sig),
                .to_sw_port (to_sw_port)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        task automatic next_cycle();
                @(posedge clk);
                #5; // drive and sample just after the edge
        endtask

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("Simulation failed");
                $fatal(1);
        endtask

        task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
                if (got !== exp) begin
                        abort_run($sformatf("FAIL at %0t ns: %s, got %0h, expected %0h",
                                $time, what, got, exp));
                end
        endtask

        task automatic wait_for_sig(input logic [1:0] value, input string step);
                int n;
                n = 0;
                while (to_sw_sig !== value) begin
                        if (n == TIMEOUT) begin
                                abort_run($sformatf("Timeout: to_sw_sig never became %0d during %s",
                                        value, step));
                        end
                        next_cycle();
                        n++;
                end
        endtask

        // acknowledge stays up 1 to 7 cycles, then release
        task automatic hold_ack(input logic [31:0] word, input bit readback);
                int hold;
                hold = 1 + (ack_count % 7);
                ack_count++;
                repeat (hold) begin
                        next_cycle();
                        check(to_sw_sig, 2'd0, "to_sw_sig during acknowledge");
                        if (readback) begin
                                check(to_sw_port, word, "to_sw_port held until release");
                        end
                end
                to_hw_sig = 2'd1;
                next_cycle();
        endtask

        task automatic load_block(input logic [1:0] cmd, input logic [127:0] data,
                                  input string what);
                wait_for_sig(2'd0, {what, " idle before load"});
                to_hw_sig = cmd;
                for (int i = 0; i < 4; i++) begin
                        to_hw_port = data[127 - 32*i -: 32]; // msw first
                        wait_for_sig(2'd1, $sformatf("%s word %0d request", what, i));
                        to_hw_sig = 2'd2;
                        wait_for_sig(2'd0, $sformatf("%s word %0d acknowledge", what, i));
                        hold_ack('0, 1'b0);
                end
                to_hw_sig = 2'd0; // port is back in WAIT
                check(to_sw_sig, 2'd0, {what, " idle after load"});
        endtask

        task automatic decrypt_and_check(input logic [127:0] expected, input string what);
                logic [31:0] word;
                wait_for_sig(2'd0, {what, " idle before decrypt"});
                to_hw_sig = CMD_RUN;
                wait_for_sig(2'd2, {what, " decrypt busy"});
                to_hw_sig = 2'd1; // readback begins once GET_FROM_AES sees this
                for (int i = 0; i < 4; i++) begin
                        wait_for_sig(2'd1, $sformatf("%s plaintext word %0d", what, i));
                        word = to_sw_port;
                        check(word, expected[127 - 32*i -: 32],
                                $sformatf("%s plaintext word %0d", what, i));
                        to_hw_sig = 2'd2;
                        wait_for_sig(2'd0, $sformatf("%s readback acknowledge %0d", what, i));
                        hold_ack(expected[127 - 32*i -: 32], 1'b1);
                end
                to_hw_sig = 2'd0;
                check(to_sw_sig, 2'd0, {what, " idle after readback"});
        endtask

        initial begin
                logic [127:0] key;
                logic [127:0] cipher;
                logic [127:0] plain;
                logic [127:0] last_key;
                logic [127:0] last_cipher;
                int           n_done;
                reset_n     = 1'b0;
                to_hw_sig   = 2'd0;
                to_hw_port  = '0;
                last_key    = '0;
                last_cipher = '0;
                n_done      = 0;
                $readmemh("aes_patterns.txt", pats);
                if ($isunknown(pats[0])) begin
                        abort_run("Could not read any pattern from aes_patterns.txt");
                end
                repeat (3) @(posedge clk);
                #5;
                reset_n = 1'b1;
                check(to_sw_sig, 2'd3, "to_sw_sig right after reset");
                next_cycle();
                check(to_sw_sig, 2'd0, "to_sw_sig idle after reset");
                for (int p = 0; p < MAX_PATS; p++) begin
                        key    = pats[3*p];
                        cipher = pats[3*p + 1];
                        plain  = pats[3*p + 2];
                        if (key === '0) begin
                                break; // end of list
                        end
                        if ($isunknown({key, cipher, plain})) begin
                                abort_run($sformatf("Pattern %0d in aes_patterns.txt is incomplete",
                                        p));
                        end
                        // only the half that changed is reloaded
                        if (n_done == 0 || cipher !== last_cipher) begin
                                load_block(CMD_MSG, cipher, $sformatf("pattern %0d message", p));
                        end
                        if (n_done == 0 || key !== last_key) begin
                                load_block(CMD_KEY, key, $sformatf("pattern %0d key", p));
                        end
                        decrypt_and_check(plain, $sformatf("pattern %0d", p));
                        last_key    = key;
                        last_cipher = cipher;
                        n_done++;
                end
                if (n_done == 0) begin
                        $display("No pattern was run, the list starts with an all-zero key");
                        $display("Simulation failed");
                        $fatal(1);
                end else begin
                        $display("Simulation passed");
                        $finish;
                end
        end

endmodule

// File: aes_decrypt_top.sv
// AES-128 decryption accelerator
`timescale 1ns/1ns
`include "aes_defs.svh"

module aes_decrypt_top (
        input  logic                      clk,
        input  logic                      reset_n,
        input  logic [1:0]                to_hw_sig,
        input  logic [`AES_HOST_WORD-1:0] to_hw_port,
        output logic [1:0]                to_sw_sig,
        output logic [`AES_HOST_WORD-1:0] to_sw_port
);
        import aes_pkg::*;

        aes_job_t   job;
        logic       start;
        aes_block_t plain;
        logic       ready;

        host_io_port u_port (
                .clk        (clk),
                .reset_n    (reset_n),
                .to_hw_sig  (to_hw_sig),
                .to_hw_port (to_hw_port),
                .to_sw_sig  (to_sw_sig),
                .to_sw_port (to_sw_port),
                .job        (job),
                .start      (start),
                .plain      (plain),
                .ready      (ready)
        );

        aes_decrypt_core u_core (
                .clk     (clk),
                .reset_n (reset_n),
                .job     (job),
                .start   (start),
                .plain   (plain),
                .ready   (ready)
        );

endmodule

// File: aes_defs.svh
// AES accelerator parameters
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// block and key width
`define AES_BLOCK_BITS 128

// mailbox word width
`define AES_HOST_WORD 32

`define AES_ROUNDS 10 // AES-128 round count

`endif

// File: aes_inv_round.sv
// AES inverse round datapath
`timescale 1ns/1ns

module aes_inv_round (
        input  aes_pkg::aes_block_t state_in,
        input  aes_pkg::aes_block_t round_key,
        input  logic                last,
        output aes_pkg::aes_block_t state_out
);
        import aes_pkg::*;

        aes_block_t shifted; // after InvShiftRows and InvSubBytes
        aes_block_t keyed;

        always_comb begin
                // row r moves right by r columns
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                shifted.b[4*c + r] = inv_sbox(state_in.b[4*((c + 4 - r) % 4) + r]);
                        end
                end
                for (int i = 0; i < 4; i++) begin
                        keyed.w[i] = shifted.w[i] ^ round_key.w[i];
                        state_out.w[i] = last ? keyed.w[i] : inv_mix_column(keyed.w[i]);
                end
        end

endmodule

// File: aes_key_schedule.sv
// AES-128 round key generator
`timescale 1ns/1ns

module aes_key_schedule (
        input  logic                clk,
        input  logic                reset_n,
        input  logic                load,
        input  aes_pkg::aes_block_t key,
        input  logic                expand,
        input  logic                back,
        output aes_pkg::aes_block_t round_key
);
        import aes_pkg::*;

        aes_block_t key_q;
        aes_block_t key_fwd;
        aes_block_t key_bwd;
        logic [7:0] rcon;
        logic [7:0] rcon_prev;

        function automatic logic [31:0] rot_sub(input logic [31:0] w);
                return {sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0]), sbox(w[31:24])};
        endfunction

        // rcon divided by x, walks 6c 36 1b 80 ... back to 01
        assign rcon_prev = rcon[0] ? (((rcon ^ 8'h1b) >> 1) | 8'h80) : (rcon >> 1);

        always_comb begin
                key_fwd.w[0] = key_q.w[0] ^ rot_sub(key_q.w[3]) ^ {rcon, 24'h0};
                key_fwd.w[1] = key_q.w[1] ^ key_fwd.w[0];
                key_fwd.w[2] = key_q.w[2] ^ key_fwd.w[1];
                key_fwd.w[3] = key_q.w[3] ^ key_fwd.w[2];

                key_bwd.w[3] = key_q.w[3] ^ key_q.w[2];
                key_bwd.w[2] = key_q.w[2] ^ key_q.w[1];
                key_bwd.w[1] = key_q.w[1] ^ key_q.w[0];
                key_bwd.w[0] = key_q.w[0] ^ rot_sub(key_bwd.w[3]) ^ {rcon_prev, 24'h0};
        end

        always_ff @(posedge clk, negedge reset_n) begin
                if (!reset_n) begin
                        rcon <= 8'h01;
                end else if (load) begin
                        rcon <= 8'h01;
                end else if (expand) begin
                        rcon <= gf_mul2(rcon);
                end else if (back) begin
                        rcon <= rcon_prev;
                end
        end

        always_ff @(posedge clk) begin
                if (load) begin
                        key_q <= key;
                end else if (expand) begin
                        key_q <= key_fwd;
                end else if (back) begin
                        key_q <= key_bwd;
                end
        end

        assign round_key = key_q;

endmodule

// File: aes_patterns.txt
// columns: key, ciphertext, expected plaintext (128-bit hex each)
// one pattern per line, a line with an all-zero key ends the list
000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
2b7e151628aed2a6abf7158809cf4f3c 3925841d02dc09fbdc118597196a0b32 3243f6a8885a308d313198a2e0370734
2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97 6bc1bee22e409f96e93d7e117393172a
2b7e151628aed2a6abf7158809cf4f3c f5d3d58503b9699de785895a96fdbaaf ae2d8a571e03ac9c9eb76fac45af8e51
2b7e151628aed2a6abf7158809cf4f3c 43b1cd7f598ece23881b00e3ed030688 30c81c46a35ce411e5fbc1191a0a52ef
0 0 0

// File: aes_pkg.sv
// AES shared types and GF(2^8) math
`include "aes_defs.svh"

package aes_pkg;

        // one 128-bit block, seen as host words or as state bytes
        typedef union packed {
                logic [0:`AES_BLOCK_BITS/`AES_HOST_WORD-1][`AES_HOST_WORD-1:0] w; // word 0 is msw
                logic [0:`AES_BLOCK_BITS/8-1][7:0]                             b; // byte 4*col+row
        } aes_block_t;

        typedef struct packed {
                aes_block_t cipher;
                aes_block_t key;
        } aes_job_t;

        function automatic logic [7:0] gf_mul2(input logic [7:0] a);
                return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00); // reduce by x^8+x^4+x^3+x+1
        endfunction

        function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
                logic [7:0] p;
                logic [7:0] x;
                p = 8'h00;
                x = a;
                for (int i = 0; i < 8; i++) begin
                        if (b[i]) begin
                                p = p ^ x;
                        end
                        x = gf_mul2(x);
                end
                return p;
        endfunction

        // inverse as a^254, zero maps to zero
        function automatic logic [7:0] gf_inv(input logic [7:0] a);
                logic [7:0] sq;
                logic [7:0] acc;
                sq = a;
                acc = 8'h01;
                for (int i = 1; i < 8; i++) begin
                        sq = gf_mul(sq, sq); // a^(2^i)
                        acc = gf_mul(acc, sq);
                end
                return acc;
        endfunction

        function automatic logic [7:0] rotl8(input logic [7:0] v, input int n);
                logic [15:0] dbl;
                dbl = {v, v} >> (8 - n);
                return dbl[7:0];
        endfunction

        function automatic logic [7:0] sbox(input logic [7:0] a);
                logic [7:0] v;
                v = gf_inv(a);
                return v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
        endfunction

        function automatic logic [7:0] inv_sbox(input logic [7:0] a);
                return gf_inv(rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05); // undo affine first
        endfunction

        function automatic logic [31:0] inv_mix_column(input logic [31:0] col);
                logic [0:3][7:0] a;
                logic [0:3][7:0] r;
                a = col; // a[0] is row 0
                for (int i = 0; i < 4; i++) begin
                        r[i] = gf_mul(a[i], 8'h0e) ^ gf_mul(a[(i + 1) % 4], 8'h0b)
                             ^ gf_mul(a[(i + 2) % 4], 8'h0d) ^ gf_mul(a[(i + 3) % 4], 8'h09);
                end
                return r;
        endfunction

endpackage

// File: host_io_port.sv
// Host mailbox port
`timescale 1ns/1ns
`include "aes_defs.svh"

module host_io_port (
        input  logic                      clk,
        input  logic                      reset_n,
        input  logic [1:0]                to_hw_sig,
        input  logic [`AES_HOST_WORD-1:0] to_hw_port,
        output logic [1:0]                to_sw_sig,
        output logic [`AES_HOST_WORD-1:0] to_sw_port,
        output aes_pkg::aes_job_t         job,
        output logic                      start,
        input  aes_pkg::aes_block_t       plain,
        input  logic                      ready
);
        import aes_pkg::*;

        localparam logic [1:0] CMD_MSG = 2'd1;
        localparam logic [1:0] CMD_KEY = 2'd2;
        localparam logic [1:0] CMD_RUN = 2'd3;
        localparam logic [1:0] HS_ACK  = 2'd2; // host took or gave the word
        localparam logic [1:0] HS_REL  = 2'd1; // host lets the port move on

        typedef enum logic [2:0] {
                RESET,
                WAIT,
                READ,
                ACK,
                SEND_TO_AES,
                GET_FROM_AES,
                SEND_BACK,
                GOT_ACK
        } state_t;

        state_t     state;
        state_t     next_state;
        logic [1:0] idx;    // word index, 0 is most significant
        logic       to_key; // current load targets the key

        always_comb begin
                next_state = state;
                case (state)
                RESET: begin
                        next_state = WAIT;
                end
                WAIT: begin
                        if (to_hw_sig == CMD_MSG || to_hw_sig == CMD_KEY) begin
                                next_state = READ;
                        end else if (to_hw_sig == CMD_RUN) begin
                                next_state = SEND_TO_AES;
                        end
                end
                READ: begin
                        if (to_hw_sig == HS_ACK) begin
                                next_state = ACK;
                        end
                end
                ACK: begin
                        if (to_hw_sig == HS_REL) begin
                                next_state = (idx == 2'd3) ? WAIT : READ;
                        end
                end
                SEND_TO_AES: begin
                        if (ready && !start) begin // old ready still up in the start cycle
                                next_state = GET_FROM_AES;
                        end
                end
                GET_FROM_AES: begin
                        if (to_hw_sig == HS_REL) begin
                                next_state = SEND_BACK;
                        end
                end
                SEND_BACK: begin
                        if (to_hw_sig == HS_ACK) begin
                                next_state = GOT_ACK;
                        end
                end
                GOT_ACK: begin
                        if (to_hw_sig == HS_REL) begin
                                next_state = (idx == 2'd3) ? WAIT : SEND_BACK;
                        end
                end
                default: begin
                        next_state = RESET;
                end
                endcase
        end

        always_comb begin
                case (state)
                RESET:                     to_sw_sig = 2'd3;
                READ, SEND_BACK:           to_sw_sig = 2'd1;
                SEND_TO_AES, GET_FROM_AES: to_sw_sig = 2'd2;
                default:                   to_sw_sig = 2'd0;
                endcase
        end

        // word stays put until the host releases it
        assign to_sw_port = (state == SEND_BACK || state == GOT_ACK) ? plain.w[idx] : '0;

        always_ff @(posedge clk, negedge reset_n) begin
                if (!reset_n) begin
                        state  <= RESET;
                        idx    <= '0;
                        to_key <= 1'b0;
                        start  <= 1'b0;
                        job    <= '0;
                end else begin
                        state <= next_state;
                        start <= (next_state == SEND_TO_AES) && (state != SEND_TO_AES);
                        if (state == WAIT) begin
                                idx    <= '0;
                                to_key <= (to_hw_sig == CMD_KEY);
                        end
                        if (state == GET_FROM_AES) begin
                                idx <= '0;
                        end
                        if ((state == ACK || state == GOT_ACK) && to_hw_sig == HS_REL) begin
                                idx <= idx + 2'd1; // wraps to 0 after the last word
                        end
                        if (state == READ) begin
                                if (to_key) begin
                                        job.key.w[idx] <= to_hw_port;
                                end else begin
                                        job.cipher.w[idx] <= to_hw_port;
                                end
                        end
                end
        end

        a_start_pulse: assert property (@(posedge clk) disable iff (!reset_n)
                start |=> !start)
                else $error("start held for more than one cycle");

endmodule

// File: tb.f
+incdir+.
aes_pkg.sv
host_io_port.sv
aes_key_schedule.sv
aes_inv_round.sv
aes_decrypt_core.sv
aes_decrypt_top.sv
aes_decrypt_tb.sv
